/* hdl/vec_axil_bridge.sv */
`timescale 1ns/1ps

module vec_axil_bridge
  import vec_pkg::*;
(
  input  logic                  i_clk,
  input  logic                  i_reset_n,
  // write address and data taken together
  input  logic                  i_awvalid,
  output logic                  o_awready,
  input  logic [AXI_ADDR_W-1:0] i_awaddr,
  input  logic                  i_wvalid,
  output logic                  o_wready,
  input  logic [XLEN-1:0]       i_wdata,
  // write response
  output logic                  o_bvalid,
  input  logic                  i_bready,
  output logic [1:0]            o_bresp,
  // read
  input  logic                  i_arvalid,
  output logic                  o_arready,
  input  logic [AXI_ADDR_W-1:0] i_araddr,
  output logic                  o_rvalid,
  input  logic                  i_rready,
  output logic [XLEN-1:0]       o_rdata,
  output logic [1:0]            o_rresp,
  // csr side
  output csr_req_t              o_csr_req,
  input  csr_rsp_t              i_csr_rsp
);

  typedef enum logic {
    IDLE,
    RESP
  } state_e;

  state_e          r_state;
  logic            r_is_rd;  // pending response belongs to R
  logic [XLEN-1:0] r_rdata;
  logic [1:0]      r_resp;

  logic            w_wr_acc;
  logic            w_rd_acc;
  logic            w_rsp_done;

  // ----------------------------------------------------------------------
  // acceptance with one transaction in flight
  // ----------------------------------------------------------------------
  assign w_wr_acc = (r_state == IDLE) && i_awvalid && i_wvalid;
  assign w_rd_acc = (r_state == IDLE) && i_arvalid && !w_wr_acc;  // write wins

  assign o_awready = w_wr_acc;
  assign o_wready  = w_wr_acc;
  assign o_arready = w_rd_acc;

  always_comb begin
    o_csr_req    = '0;
    o_csr_req.wr = w_wr_acc;
    o_csr_req.rd = w_rd_acc;
    if (w_wr_acc) begin
      o_csr_req.addr  = i_awaddr[AXI_ADDR_W-1:2];
      o_csr_req.wdata = i_wdata;
    end else begin
      o_csr_req.addr = i_araddr[AXI_ADDR_W-1:2];
    end
  end

  // ----------------------------------------------------------------------
  // response FSM
  // ----------------------------------------------------------------------
  assign w_rsp_done = r_is_rd ? i_rready : i_bready;

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_state <= IDLE;
      r_is_rd <= 1'b0;
    end else begin
      case (r_state)
        IDLE: begin
          if (w_wr_acc || w_rd_acc) begin
            r_state <= RESP;
            r_is_rd <= w_rd_acc;
          end
        end
        RESP: begin
          if (w_rsp_done) r_state <= IDLE;  // host took it
        end
        default: r_state <= IDLE;
      endcase
    end
  end

  // csr answer captured in the accept cycle
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_rdata <= '0;
      r_resp  <= AXI_RESP_OKAY;
    end else if (w_wr_acc || w_rd_acc) begin
      r_rdata <= i_csr_rsp.rdata;
      r_resp  <= i_csr_rsp.error ? AXI_RESP_SLVERR : AXI_RESP_OKAY;
    end
  end

  assign o_bvalid = (r_state == RESP) && !r_is_rd;
  assign o_rvalid = (r_state == RESP) && r_is_rd;
  assign o_bresp  = r_resp;
  assign o_rresp  = r_resp;
  assign o_rdata  = r_rdata;

endmodule

/* hdl/vec_csr_regs.sv */
`timescale 1ns/1ps

module vec_csr_regs
  import vec_pkg::*;
(
  input  logic        i_clk,
  input  logic        i_reset_n,
  input  csr_req_t    i_csr_req,
  output csr_rsp_t    o_csr_rsp,
  input  vl_cfg_t     i_vl_cfg,
  input  commit_blk_t i_commit,
  output logic        o_lmul_exception_mode
);

  logic [XLEN-1:0] r_vstart;
  logic [1:0]      r_vxrm;
  logic            r_vxsat;
  logic [XLEN-1:0] r_vscratch;  // trap value kept over an lmul change
  logic            r_lmul_exc_mode;

  logic [XLEN-1:0] w_rd_val;
  logic            w_known;     // address hits a csr
  logic            w_ro;        // not writable from the host
  logic            w_error;
  logic            w_wr_ok;

  // ----------------------------------------------------------------------
  // address decode and read mux
  // ----------------------------------------------------------------------
  always_comb begin
    w_rd_val = '0;
    w_known  = 1'b1;
    w_ro     = 1'b0;
    case (i_csr_req.addr)
      ADDR_VSTART: w_rd_val = r_vstart;
      ADDR_VXSAT:  w_rd_val = XLEN'(r_vxsat);
      ADDR_VXRM:   w_rd_val = XLEN'(r_vxrm);
      ADDR_VCSR:   w_rd_val = XLEN'({r_vxrm, r_vxsat});  // vxrm in 2:1
      ADDR_VL: begin
        w_rd_val = XLEN'(i_vl_cfg.vl);
        w_ro     = 1'b1;
      end
      ADDR_VTYPE: begin
        w_rd_val[XLEN-1] = i_vl_cfg.vill;
        w_rd_val[7:0]    = i_vl_cfg.vill ? 8'h00 : i_vl_cfg.vtype;
        w_ro             = 1'b1;
      end
      ADDR_VLENB: begin
        w_rd_val = XLEN'(VLENB);
        w_ro     = 1'b1;
      end
      ADDR_VSCRATCH: begin
        w_rd_val = r_vscratch;
        w_ro     = 1'b1;  // only a commit loads it
      end
      default: w_known = 1'b0;
    endcase
  end

  assign w_error = (i_csr_req.rd || i_csr_req.wr) &&
                   (!w_known || (i_csr_req.wr && w_ro));
  assign w_wr_ok = i_csr_req.wr && !w_error;

  assign o_csr_rsp.error = w_error;
  assign o_csr_rsp.rdata = (i_csr_req.rd && !w_error) ? w_rd_val : '0;

  // ----------------------------------------------------------------------
  // host writes
  // ----------------------------------------------------------------------
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_vstart <= '0;
      r_vxrm   <= '0;
      r_vxsat  <= 1'b0;
    end else if (w_wr_ok) begin
      case (i_csr_req.addr)
        ADDR_VSTART: r_vstart <= i_csr_req.wdata;
        ADDR_VXSAT:  r_vxsat  <= i_csr_req.wdata[0];
        ADDR_VXRM:   r_vxrm   <= i_csr_req.wdata[1:0];
        ADDR_VCSR: begin
          r_vxrm  <= i_csr_req.wdata[2:1];
          r_vxsat <= i_csr_req.wdata[0];
        end
        default: begin
        end
      endcase
    end
  end

  // ----------------------------------------------------------------------
  // commit events
  // ----------------------------------------------------------------------
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_lmul_exc_mode <= 1'b0;
      r_vscratch      <= '0;
    end else if (i_commit.valid) begin
      case (i_commit.except_type)
        EXC_LMUL_CHANGE: begin
          r_lmul_exc_mode <= 1'b1;
          r_vscratch      <= i_commit.tval;
        end
        EXC_MRET,
        EXC_SRET,
        EXC_URET: r_lmul_exc_mode <= 1'b0;  // back from the trap handler
        default: begin
        end
      endcase
    end
  end

  assign o_lmul_exception_mode = r_lmul_exc_mode;

endmodule

/* hdl/vec_csr_top.sv */
`timescale 1ns/1ps

module vec_csr_top
  import vec_pkg::*;
(
  input  logic                  i_clk,
  input  logic                  i_reset_n,
  // AXI4-Lite slave
  input  logic                  i_awvalid,
  output logic                  o_awready,
  input  logic [AXI_ADDR_W-1:0] i_awaddr,
  input  logic                  i_wvalid,
  output logic                  o_wready,
  input  logic [XLEN-1:0]       i_wdata,
  output logic                  o_bvalid,
  input  logic                  i_bready,
  output logic [1:0]            o_bresp,
  input  logic                  i_arvalid,
  output logic                  o_arready,
  input  logic [AXI_ADDR_W-1:0] i_araddr,
  output logic                  o_rvalid,
  input  logic                  i_rready,
  output logic [XLEN-1:0]       o_rdata,
  output logic [1:0]            o_rresp,
  // core side
  input  vset_req_t             i_vset,
  input  commit_blk_t           i_commit,
  output vl_cfg_t               o_vl_cfg,
  output logic                  o_lmul_exception_mode
);

  csr_req_t w_csr_req;
  csr_rsp_t w_csr_rsp;

  vec_axil_bridge bridge_i (
    .i_clk     (i_clk),
    .i_reset_n (i_reset_n),
    .i_awvalid (i_awvalid),
    .o_awready (o_awready),
    .i_awaddr  (i_awaddr),
    .i_wvalid  (i_wvalid),
    .o_wready  (o_wready),
    .i_wdata   (i_wdata),
    .o_bvalid  (o_bvalid),
    .i_bready  (i_bready),
    .o_bresp   (o_bresp),
    .i_arvalid (i_arvalid),
    .o_arready (o_arready),
    .i_araddr  (i_araddr),
    .o_rvalid  (o_rvalid),
    .i_rready  (i_rready),
    .o_rdata   (o_rdata),
    .o_rresp   (o_rresp),
    .o_csr_req (w_csr_req),
    .i_csr_rsp (w_csr_rsp)
  );

  vec_vsetvl vsetvl_i (
    .i_clk     (i_clk),
    .i_reset_n (i_reset_n),
    .i_vset    (i_vset),
    .o_vl_cfg  (o_vl_cfg)
  );

  // vl and vtype reads come straight from the vsetvl registers
  vec_csr_regs regs_i (
    .i_clk                 (i_clk),
    .i_reset_n             (i_reset_n),
    .i_csr_req             (w_csr_req),
    .o_csr_rsp             (w_csr_rsp),
    .i_vl_cfg              (o_vl_cfg),
    .i_commit              (i_commit),
    .o_lmul_exception_mode (o_lmul_exception_mode)
  );

endmodule

/* hdl/vec_pkg.sv */
package vec_pkg;

  // ----------------------------------------------------------------------
  // sizes
  // ----------------------------------------------------------------------
  localparam int unsigned XLEN       = 32;
  localparam int unsigned VLENB      = 16;  // bytes per vector register
  localparam int unsigned VL_W       = 8;   // holds VLMAX up to 128
  localparam int unsigned CSR_ADDR_W = 12;
  localparam int unsigned AXI_ADDR_W = 14;  // csr address sits in 13:2

  // csr map
  localparam logic [CSR_ADDR_W-1:0] ADDR_VSTART   = 12'h008;
  localparam logic [CSR_ADDR_W-1:0] ADDR_VXSAT    = 12'h009;
  localparam logic [CSR_ADDR_W-1:0] ADDR_VXRM     = 12'h00A;
  localparam logic [CSR_ADDR_W-1:0] ADDR_VCSR     = 12'h00F;
  localparam logic [CSR_ADDR_W-1:0] ADDR_VL       = 12'hC20;
  localparam logic [CSR_ADDR_W-1:0] ADDR_VTYPE    = 12'hC21;
  localparam logic [CSR_ADDR_W-1:0] ADDR_VLENB    = 12'hC22;
  localparam logic [CSR_ADDR_W-1:0] ADDR_VSCRATCH = 12'h7C0;

  localparam logic [1:0] AXI_RESP_OKAY   = 2'b00;
  localparam logic [1:0] AXI_RESP_SLVERR = 2'b10;

  // ----------------------------------------------------------------------
  // types
  // ----------------------------------------------------------------------
  typedef enum logic [2:0] {
    EXC_NONE        = 3'd0,
    EXC_LMUL_CHANGE = 3'd1,
    EXC_MRET        = 3'd2,
    EXC_SRET        = 3'd3,
    EXC_URET        = 3'd4
  } except_type_e;

  typedef struct packed {
    logic       vma;
    logic       vta;
    logic [2:0] vsew;
    logic [2:0] vlmul;  // integer lmul only
  } vtype_t;

  typedef struct packed {
    logic            valid;
    logic [XLEN-1:0] avl;
    vtype_t          vtype;
  } vset_req_t;

  typedef struct packed {
    logic            valid;
    except_type_e    except_type;
    logic [XLEN-1:0] tval;
  } commit_blk_t;

  typedef struct packed {
    logic                  rd;
    logic                  wr;
    logic [CSR_ADDR_W-1:0] addr;
    logic [XLEN-1:0]       wdata;
  } csr_req_t;

  typedef struct packed {
    logic [XLEN-1:0] rdata;
    logic            error;
  } csr_rsp_t;

  typedef struct packed {
    logic [VL_W-1:0] vl;
    vtype_t          vtype;
    logic            vill;
  } vl_cfg_t;

endpackage

/* hdl/vec_vsetvl.sv */
`timescale 1ns/1ps

module vec_vsetvl
  import vec_pkg::*;
(
  input  logic      i_clk,
  input  logic      i_reset_n,
  input  vset_req_t i_vset,
  output vl_cfg_t   o_vl_cfg
);

  vl_cfg_t         r_cfg;

  logic            w_vill;
  logic [XLEN-1:0] w_vlmax;  // wide, so the compare with avl is exact
  logic [VL_W-1:0] w_vl;

  // ----------------------------------------------------------------------
  // legality and VLMAX
  // ----------------------------------------------------------------------
  // reserved sew or fractional/reserved lmul
  assign w_vill = (i_vset.vtype.vsew > 3'd3) || (i_vset.vtype.vlmul > 3'd3);

  // VLENB * lmul / (sew bytes)
  assign w_vlmax = (XLEN'(VLENB) << i_vset.vtype.vlmul[1:0]) >> i_vset.vtype.vsew[1:0];

  assign w_vl = (i_vset.avl < w_vlmax) ? i_vset.avl[VL_W-1:0] : w_vlmax[VL_W-1:0];

  // ----------------------------------------------------------------------
  // vl / vtype / vill
  // ----------------------------------------------------------------------
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_cfg.vl    <= '0;
      r_cfg.vtype <= '0;
      r_cfg.vill  <= 1'b1;  // no legal setting yet
    end else if (i_vset.valid) begin
      if (w_vill) begin
        r_cfg.vl    <= '0;
        r_cfg.vtype <= '0;
        r_cfg.vill  <= 1'b1;
      end else begin
        r_cfg.vl    <= w_vl;
        r_cfg.vtype <= i_vset.vtype;
        r_cfg.vill  <= 1'b0;
      end
    end
  end

  assign o_vl_cfg = r_cfg;

endmodule

/* run.sh */
#!/bin/sh
# build and run the vector CSR testbench with Verilator
rm -f sim.log &&
verilator --binary --timing --assert -f sim.f --top-module vec_csr_tb \
  -o vec_csr_sim > build.log 2>&1 &&
./obj_dir/vec_csr_sim > sim.log 2>&1
grep -q "STATUS: PASS" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }

/* sim.f */
hdl/vec_pkg.sv
hdl/vec_axil_bridge.sv
hdl/vec_vsetvl.sv
hdl/vec_csr_regs.sv
hdl/vec_csr_top.sv
verif/vec_csr_checker.sv
verif/vec_csr_monitor.sv
verif/vec_csr_tb.sv

/* verif/vec_csr_checker.sv */
`timescale 1ns/1ps

module vec_csr_checker
  import vec_pkg::*;
(
  input logic            i_clk,
  input logic            i_reset_n,
  input logic            i_awvalid,
  input logic            i_awready,
  input logic            i_wvalid,
  input logic            i_wready,
  input logic            i_arvalid,
  input logic            i_arready,
  input logic            i_bvalid,
  input logic            i_bready,
  input logic [1:0]      i_bresp,
  input logic            i_rvalid,
  input logic            i_rready,
  input logic [XLEN-1:0] i_rdata,
  input logic [1:0]      i_rresp
);

  // ----------------------------------------------------------------------
  // response channels hold until the host takes them
  // ----------------------------------------------------------------------
  b_hold: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_bvalid && !i_bready |=> i_bvalid && $stable(i_bresp))
    else $error("bvalid dropped or bresp changed before bready");

  r_hold: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_rvalid && !i_rready |=> i_rvalid && $stable(i_rdata) && $stable(i_rresp))
    else $error("rvalid dropped or read data changed before rready");

  // response one cycle after the handshake
  b_lat: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_awvalid && i_awready && i_wvalid && i_wready |=> i_bvalid)
    else $error("bvalid did not follow the write handshake");

  r_lat: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_arvalid && i_arready |=> i_rvalid)
    else $error("rvalid did not follow the read handshake");

endmodule

bind vec_csr_top vec_csr_checker checker_i (
  .i_clk     (i_clk),
  .i_reset_n (i_reset_n),
  .i_awvalid (i_awvalid),
  .i_awready (o_awready),
  .i_wvalid  (i_wvalid),
  .i_wready  (o_wready),
  .i_arvalid (i_arvalid),
  .i_arready (o_arready),
  .i_bvalid  (o_bvalid),
  .i_bready  (i_bready),
  .i_bresp   (o_bresp),
  .i_rvalid  (o_rvalid),
  .i_rready  (i_rready),
  .i_rdata   (o_rdata),
  .i_rresp   (o_rresp)
);

/* verif/vec_csr_monitor.sv */
`timescale 1ns/1ps

module vec_csr_monitor
  import vec_pkg::*;
(
  input  logic            i_clk,
  input  logic            i_reset_n,
  input  logic [2:0]      i_test_id,
  // DUT side
  input  logic            i_awready,
  input  logic            i_wready,
  input  logic            i_arready,
  input  logic            i_bvalid,
  input  logic            i_bready,
  input  logic [1:0]      i_bresp,
  input  logic            i_rvalid,
  input  logic            i_rready,
  input  logic [XLEN-1:0] i_rdata,
  input  logic [1:0]      i_rresp,
  input  vl_cfg_t         i_vl_cfg,
  input  logic            i_lmul_mode,
  // model side
  input  logic [1:0]      i_exp_resp,
  input  logic [XLEN-1:0] i_exp_rdata,
  input  vl_cfg_t         i_exp_cfg,
  input  logic            i_exp_mode,
  output int              o_errors
);

  vl_cfg_t r_exp_cfg;   // model value one edge behind
  logic    r_exp_mode;
  int      errors = 0;

  function automatic string test_name(input logic [2:0] id);
    case (id)
      3'd1:    return "csr_rw";
      3'd2:    return "vsetvl";
      3'd3:    return "bad_access";
      3'd4:    return "commit";
      3'd5:    return "mixed";
      default: return "reset";
    endcase
  endfunction

  always @(posedge i_clk) begin
    if (i_reset_n) begin
      if (i_vl_cfg !== r_exp_cfg) begin
        $display("error %s: vl_cfg expected %h actual %h",
                 test_name(i_test_id), r_exp_cfg, i_vl_cfg);
        errors++;
      end
      if (i_lmul_mode !== r_exp_mode) begin
        $display("error %s: lmul mode expected %b actual %b",
                 test_name(i_test_id), r_exp_mode, i_lmul_mode);
        errors++;
      end
      if (i_bvalid && i_bready && (i_bresp !== i_exp_resp)) begin
        $display("error %s: bresp expected %h actual %h",
                 test_name(i_test_id), i_exp_resp, i_bresp);
        errors++;
      end
      if (i_rvalid && i_rready) begin
        if (i_rresp !== i_exp_resp) begin
          $display("error %s: rresp expected %h actual %h",
                   test_name(i_test_id), i_exp_resp, i_rresp);
          errors++;
        end
        if (i_rdata !== i_exp_rdata) begin
          $display("error %s: rdata expected %h actual %h",
                   test_name(i_test_id), i_exp_rdata, i_rdata);
          errors++;
        end
      end
      if (i_awready !== i_wready) begin
        $display("awready and wready did not rise together");
        errors++;
      end
      if ((i_bvalid || i_rvalid) && (i_awready || i_wready || i_arready)) begin
        $display("a new transaction was accepted while a response was pending");
        errors++;
      end
    end
    r_exp_cfg  = i_exp_cfg;   // registers update on this edge
    r_exp_mode = i_exp_mode;
  end

  assign o_errors = errors;

endmodule

/* verif/vec_csr_tb.sv */
`timescale 1ns/1ps

module vec_csr_tb
  import vec_pkg::*;
();

  logic                  clk;
  logic                  reset_n;
  logic                  awvalid, awready, wvalid, wready, bvalid, bready;
  logic                  arvalid, arready, rvalid, rready;
  logic [AXI_ADDR_W-1:0] awaddr, araddr;
  logic [XLEN-1:0]       wdata, rdata;
  logic [1:0]            bresp, rresp;
  vset_req_t             vset;
  commit_blk_t           commit;
  vl_cfg_t               vl_cfg;
  logic                  lmul_mode;

  // reference model state
  logic [XLEN-1:0]       m_vstart, m_vscratch;
  logic [1:0]            m_vxrm;
  logic                  m_vxsat, m_mode;
  vl_cfg_t               m_cfg;
  logic [1:0]            exp_resp;
  logic [XLEN-1:0]       exp_rdata;
  logic [2:0]            test_id;
  int                    mon_errors;
  int                    timeouts;
  bit                    finished;

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  vec_csr_top dut_i (
    .i_clk (clk), .i_reset_n (reset_n),
    .i_awvalid (awvalid), .o_awready (awready), .i_awaddr (awaddr),
    .i_wvalid (wvalid), .o_wready (wready), .i_wdata (wdata),
    .o_bvalid (bvalid), .i_bready (bready), .o_bresp (bresp),
    .i_arvalid (arvalid), .o_arready (arready), .i_araddr (araddr),
    .o_rvalid (rvalid), .i_rready (rready), .o_rdata (rdata), .o_rresp (rresp),
    .i_vset (vset), .i_commit (commit),
    .o_vl_cfg (vl_cfg), .o_lmul_exception_mode (lmul_mode)
  );

  vec_csr_monitor mon_i (
    .i_clk (clk), .i_reset_n (reset_n), .i_test_id (test_id),
    .i_awready (awready), .i_wready (wready), .i_arready (arready),
    .i_bvalid (bvalid), .i_bready (bready), .i_bresp (bresp),
    .i_rvalid (rvalid), .i_rready (rready), .i_rdata (rdata), .i_rresp (rresp),
    .i_vl_cfg (vl_cfg), .i_lmul_mode (lmul_mode),
    .i_exp_resp (exp_resp), .i_exp_rdata (exp_rdata),
    .i_exp_cfg (m_cfg), .i_exp_mode (m_mode), .o_errors (mon_errors)
  );

  // ----------------------------------------------------------------------
  // model
  // ----------------------------------------------------------------------
  function automatic logic chance(input int unsigned pct);
    return ($urandom % 100) < pct;
  endfunction

  function automatic logic [11:0] csr_addr(input int i);
    case (i)
      0:       return ADDR_VSTART;
      1:       return ADDR_VXSAT;
      2:       return ADDR_VXRM;
      3:       return ADDR_VCSR;
      4:       return ADDR_VL;
      5:       return ADDR_VTYPE;
      6:       return ADDR_VLENB;
      default: return ADDR_VSCRATCH;
    endcase
  endfunction

  function automatic logic is_csr(input logic [11:0] a);
    logic hit;
    hit = 1'b0;
    for (int i = 0; i < 8; i++) begin
      if (csr_addr(i) == a) hit = 1'b1;
    end
    return hit;
  endfunction

  // sets the expected response and applies a legal write
  task automatic model_access(input logic wr, input logic [11:0] addr,
                              input logic [XLEN-1:0] data);
    logic            err;
    logic [XLEN-1:0] val;
    err = 1'b0;
    val = '0;
    case (addr)
      ADDR_VSTART:   val = m_vstart;
      ADDR_VXSAT:    val = {31'b0, m_vxsat};
      ADDR_VXRM:     val = {30'b0, m_vxrm};
      ADDR_VCSR:     val = {29'b0, m_vxrm, m_vxsat};
      ADDR_VL:       val = {24'b0, m_cfg.vl};
      ADDR_VTYPE:    val = {m_cfg.vill, 23'b0, m_cfg.vill ? 8'h00 : 8'(m_cfg.vtype)};
      ADDR_VLENB:    val = 32'd16;
      ADDR_VSCRATCH: val = m_vscratch;
      default:       err = 1'b1;
    endcase
    if (wr && !(addr inside {ADDR_VSTART, ADDR_VXSAT, ADDR_VXRM, ADDR_VCSR})) err = 1'b1;
    exp_resp  = err ? AXI_RESP_SLVERR : AXI_RESP_OKAY;
    exp_rdata = (err || wr) ? '0 : val;
    if (wr && !err) begin
      case (addr)
        ADDR_VSTART: m_vstart = data;
        ADDR_VXSAT:  m_vxsat  = data[0];
        ADDR_VXRM:   m_vxrm   = data[1:0];
        default: begin
          m_vxrm  = data[2:1];
          m_vxsat = data[0];
        end
      endcase
    end
  endtask

  // ----------------------------------------------------------------------
  // AXI4-Lite host tasks start and end on a falling edge
  // ----------------------------------------------------------------------
  task automatic wait_accept(input logic is_rd);
    int   n;
    logic acc;
    n   = 0;
    acc = 1'b0;
    while (!acc && n < 64) begin
      @(posedge clk);
      acc = is_rd ? arready : (awready && wready);
      n++;
    end
    @(negedge clk);
    awvalid = 1'b0;
    wvalid  = 1'b0;
    arvalid = 1'b0;
    if (!acc) begin
      $display("timeout: request not accepted within 64 cycles");
      timeouts++;
    end
  endtask

  task automatic wait_resp(input logic is_rd);
    int   n;
    logic got;
    n   = 0;
    got = 1'b0;
    while (!got && n < 64) begin
      bready = chance(60);
      rready = chance(60);
      if (is_rd) begin
        awvalid = chance(30);  // stray request that must stay blocked
        wvalid  = awvalid;
        awaddr  = {ADDR_VSTART, 2'b00};
        wdata   = $urandom;
      end else begin
        arvalid = chance(30);
        araddr  = {ADDR_VLENB, 2'b00};
      end
      @(posedge clk);
      got = is_rd ? (rvalid && rready) : (bvalid && bready);
      n++;
      @(negedge clk);
    end
    bready  = 1'b0;
    rready  = 1'b0;
    awvalid = 1'b0;
    wvalid  = 1'b0;
    arvalid = 1'b0;
    if (!got) begin
      $display("timeout: no %s response within 64 cycles", is_rd ? "read" : "write");
      timeouts++;
    end
  endtask

  task automatic axi_write(input logic [11:0] addr, input logic [XLEN-1:0] data);
    model_access(1'b1, addr, data);
    awaddr  = {addr, 2'b00};
    wdata   = data;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    wait_accept(1'b0);
    wait_resp(1'b0);
  endtask

  task automatic axi_read(input logic [11:0] addr);
    model_access(1'b0, addr, '0);
    araddr  = {addr, 2'b00};
    arvalid = 1'b1;
    wait_accept(1'b1);
    wait_resp(1'b1);
  endtask

  // ----------------------------------------------------------------------
  // core side pulses
  // ----------------------------------------------------------------------
  task automatic random_vset();
    int unsigned     rnd;
    vtype_t          vt;
    logic [XLEN-1:0] avl;
    logic [XLEN-1:0] vlmax;
    rnd = $urandom;
    vt  = rnd[7:0];
    if (chance(70)) begin  // mostly legal encodings
      vt.vsew[2]  = 1'b0;
      vt.vlmul[2] = 1'b0;
    end
    avl = chance(20) ? $urandom : $urandom_range(140, 0);
    if (vt.vsew > 3'd3 || vt.vlmul > 3'd3) begin
      m_cfg      = '0;
      m_cfg.vill = 1'b1;
    end else begin
      vlmax       = (32'd16 * (32'd1 << vt.vlmul)) / (32'd1 << vt.vsew);  // bytes * lmul / sew
      m_cfg.vl    = (avl < vlmax) ? avl[VL_W-1:0] : vlmax[VL_W-1:0];
      m_cfg.vtype = vt;
      m_cfg.vill  = 1'b0;
    end
    vset.valid = 1'b1;
    vset.avl   = avl;
    vset.vtype = vt;
    @(negedge clk);
    vset.valid = 1'b0;
  endtask

  task automatic do_commit(input except_type_e kind, input logic [XLEN-1:0] tval);
    commit.valid       = 1'b1;
    commit.except_type = kind;
    commit.tval        = tval;
    case (kind)
      EXC_LMUL_CHANGE: begin
        m_mode     = 1'b1;
        m_vscratch = tval;
      end
      EXC_MRET, EXC_SRET, EXC_URET: m_mode = 1'b0;
      default: begin
      end
    endcase
    @(negedge clk);
    commit.valid = 1'b0;
  endtask

  task automatic random_commit();
    except_type_e kind;
    case ($urandom_range(4, 0))
      0:       kind = EXC_NONE;
      1:       kind = EXC_LMUL_CHANGE;
      2:       kind = EXC_MRET;
      3:       kind = EXC_SRET;
      default: kind = EXC_URET;
    endcase
    do_commit(kind, $urandom);
    axi_read(ADDR_VSCRATCH);
  endtask

  // ----------------------------------------------------------------------
  // main sequence
  // ----------------------------------------------------------------------
  initial begin
    logic [11:0] addr;
    void'($urandom(39));
    reset_n  = 1'b0;
    awvalid  = 1'b0;
    wvalid   = 1'b0;
    arvalid  = 1'b0;
    bready   = 1'b0;
    rready   = 1'b0;
    awaddr   = '0;
    araddr   = '0;
    wdata    = '0;
    vset     = '0;
    commit   = '0;
    m_vstart = '0;
    m_vscratch = '0;
    m_vxrm   = '0;
    m_vxsat  = 1'b0;
    m_mode   = 1'b0;
    m_cfg    = '0;
    m_cfg.vill = 1'b1;
    exp_resp  = AXI_RESP_OKAY;
    exp_rdata = '0;
    timeouts  = 0;
    finished  = 1'b0;
    test_id   = 3'd6;
    repeat (4) @(negedge clk);
    reset_n = 1'b1;
    @(negedge clk);
    for (int i = 0; i < 8; i++) axi_read(csr_addr(i));  // reset values

    test_id = 3'd1;
    for (int i = 0; i < 40; i++) begin
      addr = csr_addr(int'($urandom_range(3, 0)));
      axi_write(addr, $urandom);
      axi_read(addr);
      axi_read(csr_addr(int'($urandom_range(3, 0))));
    end

    test_id = 3'd2;
    for (int i = 0; i < 40; i++) begin
      random_vset();
      axi_read(ADDR_VL);
      axi_read(ADDR_VTYPE);
    end

    test_id = 3'd3;
    axi_read(ADDR_VLENB);
    for (int i = 0; i < 20; i++) begin
      axi_write(csr_addr(int'($urandom_range(7, 4))), $urandom);
      do begin
        addr = 12'($urandom_range(4095, 0));
      end while (is_csr(addr));
      axi_write(addr, $urandom);
      axi_read(addr);
    end
    for (int i = 0; i < 8; i++) axi_read(csr_addr(i));  // nothing moved

    test_id = 3'd4;
    do_commit(EXC_LMUL_CHANGE, $urandom);
    axi_read(ADDR_VSCRATCH);
    for (int i = 0; i < 30; i++) random_commit();

    test_id = 3'd5;
    for (int i = 0; i < 60; i++) begin
      case ($urandom_range(3, 0))
        0:       axi_write(csr_addr(int'($urandom_range(3, 0))), $urandom);
        1:       random_vset();
        2:       random_commit();
        default: axi_read(csr_addr(int'($urandom_range(7, 0))));
      endcase
    end

    repeat (2) @(negedge clk);
    finished = 1'b1;
    $display("errors: compare=%0d timeout=%0d", mon_errors, timeouts);
    if (mon_errors == 0 && timeouts == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

  // run stopped before the end of the sequence
  final begin
    if (!finished) $display("STATUS: FAIL");
  end

endmodule
